//--- am_lock_settings.svh
`ifndef AM_LOCK_SETTINGS_SVH
`define AM_LOCK_SETTINGS_SVH

// coded block stream
`define NB_DATA_CODED   66      // sync header plus payload
`define N_LANES         4       // logical lanes in this build
`define NB_LANE_ID      2

// marker timing and fields
`define AM_PERIOD       64      // blocks from marker to marker, marker included
`define NB_AM           48      // six marker bytes, BIP bytes left out
`define NB_BIP          8

// lock control
`define NB_THR          4       // lock and unlock threshold width
`define NB_ERR_CNT      16      // BIP error counter

`endif

//--- pcs_block_pkg.sv
`include "am_lock_settings.svh"

package pcs_block_pkg;

	localparam int NB_SH      = 2;
	localparam int NB_PAYLOAD = `NB_DATA_CODED - NB_SH;
	localparam int NB_AM_HALF = `NB_AM / 2;

	localparam logic [NB_SH-1:0] CTRL_SH  = 2'b10;     // control block header
	localparam logic [6:0]       PCS_IDLE = 7'h00;     // idle control character

	typedef enum logic [7:0] {
		BT_CTRL = 8'h1E                                 // all control characters
	} block_type_t;

	// one coded block word, header on top
	typedef struct packed {
		logic [NB_SH-1:0]      sh;
		logic [NB_PAYLOAD-1:0] payload;
	} coded_block_t;

	// marker payload layout
	typedef struct packed {
		logic [NB_AM_HALF-1:0] am_first;                // m0..m2
		logic [`NB_BIP-1:0]    bip3;
		logic [NB_AM_HALF-1:0] am_second;               // m4..m6
		logic [`NB_BIP-1:0]    bip7;
	} am_fields_t;

	localparam coded_block_t IDLE_BLOCK = '{
		sh:      CTRL_SH,
		payload: {BT_CTRL, {8{PCS_IDLE}}}
	};

endpackage

//--- am_lock_pkg.sv
`include "am_lock_settings.svh"

package am_lock_pkg;

	localparam int NB_PERIOD_CNT = $clog2(`AM_PERIOD);

	typedef enum logic [1:0] {
		ST_WAIT_BLOCK,                                  // no block lock yet
		ST_SEARCH,                                      // any lane marker accepted
		ST_COUNT,                                       // inside a marker period
		ST_CHECK                                        // next block must be a marker
	} lock_state_t;

	typedef struct packed {
		logic am_lock;
		logic start_of_lane;
		logic resync;
	} lock_status_t;

	// marker values per lane, first three bytes then last three
	localparam logic [`N_LANES-1:0][`NB_AM-1:0] am_table = {
		48'h4D957B_B26A84,                              // lane 3
		48'h594BE8_A6B417,                              // lane 2
		48'h9D718E_628E71,                              // lane 1
		48'hC16821_3E97DE                               // lane 0
	};

endpackage

//--- am_comparator.sv
`timescale 1ns/1ps
`include "am_lock_settings.svh"

module am_comparator
	import pcs_block_pkg::*, am_lock_pkg::*;
(
	input  coded_block_t            i_block,
	input  logic [`NB_AM-1:0]       i_compare_mask,  // 1 means compare this bit
	input  logic [`N_LANES-1:0]     i_match_mask,    // lanes still allowed
	input  logic                    i_enable_mask,
	output logic                    o_match,
	output logic [`N_LANES-1:0]     o_match_vector,
	output logic [`NB_LANE_ID-1:0]  o_lane_id
);

am_fields_t             fields;
logic [`NB_AM-1:0]      am_value;
logic                   is_ctrl;
logic [`N_LANES-1:0]    hit;
logic [`N_LANES-1:0]    allowed;

assign fields   = i_block.payload;
assign am_value = {fields.am_first, fields.am_second};   // bip bytes dropped
assign is_ctrl  = (i_block.sh == CTRL_SH);

always_comb
begin
	for (int l = 0; l < `N_LANES; l++)
		hit[l] = is_ctrl && (((am_value ^ am_table[l]) & i_compare_mask) == '0);
end

assign allowed        = i_enable_mask ? i_match_mask : {`N_LANES{1'b1}};
assign o_match_vector = hit & allowed;
assign o_match        = |o_match_vector;

// lowest lane wins when the mask lets several through
always_comb
begin
	o_lane_id = '0;
	for (int l = `N_LANES-1; l >= 0; l--)
		if (o_match_vector[l])
			o_lane_id = l[`NB_LANE_ID-1:0];
end

endmodule

//--- am_lock_fsm.sv
`timescale 1ns/1ps
`include "am_lock_settings.svh"

module am_lock_fsm
	import am_lock_pkg::*;
(
	input  logic                    i_clock,
	input  logic                    i_rst,
	input  logic                    i_enable,
	input  logic                    i_valid,
	input  logic                    i_block_lock,
	input  logic                    i_match,
	input  logic [`N_LANES-1:0]     i_match_vector,
	input  logic [`NB_THR-1:0]      i_valid_thr,
	input  logic [`NB_THR-1:0]      i_invalid_thr,
	output logic [`N_LANES-1:0]     o_match_mask,
	output logic                    o_enable_mask,
	output lock_status_t            o_status
);

lock_state_t                state, state_next;
logic [NB_PERIOD_CNT-1:0]   period_cnt, period_cnt_next;
logic [`NB_THR-1:0]         good_cnt, good_cnt_next, good_inc;
logic [`NB_THR-1:0]         bad_cnt, bad_cnt_next, bad_inc;
logic [`N_LANES-1:0]        mask_next;
logic                       mask_en_next;
logic                       am_lock, am_lock_next;
logic                       sol;
logic                       resync;
logic                       step;

assign step     = i_enable & i_valid;
assign good_inc = (good_cnt == '1) ? good_cnt : good_cnt + 1'b1;     // saturating
assign bad_inc  = (bad_cnt == '1) ? bad_cnt : bad_cnt + 1'b1;

always_comb
begin
	state_next      = state;
	period_cnt_next = period_cnt;
	good_cnt_next   = good_cnt;
	bad_cnt_next    = bad_cnt;
	mask_next       = o_match_mask;
	mask_en_next    = o_enable_mask;
	am_lock_next    = am_lock;
	sol             = 1'b0;
	resync          = 1'b0;
	if (i_enable && !i_block_lock)
	begin
		state_next    = ST_WAIT_BLOCK;                   // from any state
		good_cnt_next = '0;
		bad_cnt_next  = '0;
		mask_en_next  = 1'b0;
		am_lock_next  = 1'b0;
		resync        = am_lock;
	end
	else
	begin
		case (state)
		ST_WAIT_BLOCK:
			if (i_enable)
				state_next = ST_SEARCH;
		ST_SEARCH:
			if (step && i_match)
			begin
				mask_next       = i_match_vector;
				mask_en_next    = 1'b1;
				good_cnt_next   = 1;
				bad_cnt_next    = '0;
				period_cnt_next = '0;
				state_next      = ST_COUNT;
			end
		ST_COUNT:
			if (step)
			begin
				if (period_cnt == NB_PERIOD_CNT'(`AM_PERIOD-2))
				begin
					period_cnt_next = '0;
					state_next      = ST_CHECK;          // next block is the marker slot
				end
				else
					period_cnt_next = period_cnt + 1'b1;
			end
		ST_CHECK:
			if (step)
			begin
				state_next = ST_COUNT;
				if (i_match)
				begin
					good_cnt_next = good_inc;
					bad_cnt_next  = '0;
					am_lock_next  = am_lock | (good_inc >= i_valid_thr);
					sol           = am_lock_next;
				end
				else if (!am_lock || bad_inc >= i_invalid_thr)
				begin
					state_next    = ST_SEARCH;           // give up on this lane
					good_cnt_next = '0;
					bad_cnt_next  = '0;
					mask_en_next  = 1'b0;
					am_lock_next  = 1'b0;
					resync        = 1'b1;
				end
				else
				begin
					bad_cnt_next  = bad_inc;             // locked, keep the period
					good_cnt_next = '0;
				end
			end
		default:
			state_next = ST_WAIT_BLOCK;
		endcase
	end
end

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		state         <= ST_WAIT_BLOCK;
		period_cnt    <= '0;
		good_cnt      <= '0;
		bad_cnt       <= '0;
		o_match_mask  <= '0;
		o_enable_mask <= 1'b0;
		am_lock       <= 1'b0;
	end
	else
	begin
		state         <= state_next;
		period_cnt    <= period_cnt_next;
		good_cnt      <= good_cnt_next;
		bad_cnt       <= bad_cnt_next;
		o_match_mask  <= mask_next;
		o_enable_mask <= mask_en_next;
		am_lock       <= am_lock_next;
	end
end

// status for the block being judged now
assign o_status = '{am_lock: am_lock_next, start_of_lane: sol, resync: resync};

endmodule

//--- bip_checker.sv
`timescale 1ns/1ps
`include "am_lock_settings.svh"

module bip_checker
	import pcs_block_pkg::*;
(
	input  logic                    i_clock,
	input  logic                    i_rst,
	input  logic                    i_enable,
	input  logic                    i_valid,
	input  coded_block_t            i_block,
	input  logic                    i_start_of_lane,
	input  logic                    i_resync,
	output logic [`NB_ERR_CNT-1:0]  o_error_count
);

// bit k of the word lands on parity bit k mod 8
function automatic logic [`NB_BIP-1:0] bip_fold(input coded_block_t blk);
	logic [`NB_DATA_CODED-1:0] word;
	logic [`NB_BIP-1:0]        acc;
	word = {blk.payload, blk.sh};                    // bit 0 is sync header lsb
	acc  = '0;
	for (int k = 0; k < `NB_DATA_CODED; k++)
		acc[k % `NB_BIP] ^= word[k];
	return acc;
endfunction

am_fields_t             fields;
am_fields_t             chk_fields;
coded_block_t           chk_block;
logic [`NB_BIP-1:0]     bip_sum;
logic [`NB_BIP-1:0]     bip_calc;
logic                   primed;                      // a full period is in the sum
logic                   bip_err;

always_comb
begin
	fields     = i_block.payload;
	chk_fields = fields;
	if (i_start_of_lane)
		chk_fields.bip3 = '0;                        // marker counts without its own bip3
	chk_block.sh      = i_block.sh;
	chk_block.payload = chk_fields;
end

assign bip_calc = bip_sum ^ bip_fold(chk_block);

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		bip_sum       <= '0;
		primed        <= 1'b0;
		bip_err       <= 1'b0;
		o_error_count <= '0;
	end
	else if (i_enable)
	begin
		bip_err <= 1'b0;
		if (bip_err && o_error_count != '1)
			o_error_count <= o_error_count + 1'b1;
		if (i_resync)
		begin
			bip_sum       <= '0;
			primed        <= 1'b0;
			o_error_count <= '0;
		end
		else if (i_valid && i_start_of_lane)
		begin
			bip_err <= primed && (bip_calc != fields.bip3);
			primed  <= 1'b1;
			bip_sum <= '0;                           // reseed for the next period
		end
		else if (i_valid)
			bip_sum <= bip_calc;
	end
end

endmodule

//--- am_lock_top.sv
`timescale 1ns/1ps
`include "am_lock_settings.svh"

module am_lock_top
	import pcs_block_pkg::*, am_lock_pkg::*;
(
	input  logic                    i_clock,
	input  logic                    i_rst,
	input  logic                    i_enable,
	input  logic                    i_valid,         // one strobe per block
	input  logic                    i_block_lock,    // from block sync
	input  coded_block_t            i_data,
	input  logic [`NB_THR-1:0]      i_valid_thr,
	input  logic [`NB_THR-1:0]      i_invalid_thr,
	input  logic [`NB_AM-1:0]       i_compare_mask,
	output coded_block_t            o_data,          // to deskew
	output logic                    o_valid,
	output logic [`NB_LANE_ID-1:0]  o_lane_id,       // to lane reorder
	output logic                    o_am_lock,
	output logic                    o_start_of_lane,
	output logic                    o_resync,
	output logic [`NB_ERR_CNT-1:0]  o_error_count
);

coded_block_t               in_data_q;
logic                       in_valid_q;
logic                       in_block_lock_q;
logic                       match;
logic [`N_LANES-1:0]        match_vector;
logic [`N_LANES-1:0]        match_mask;
logic                       enable_mask;
logic [`NB_LANE_ID-1:0]     lane_id;
lock_status_t               status;

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		in_valid_q      <= 1'b0;
		in_block_lock_q <= 1'b0;
	end
	else
	begin
		in_valid_q <= i_enable & i_valid;
		if (i_enable)
			in_block_lock_q <= i_block_lock;
	end
end

always_ff @(posedge i_clock)
begin
	if (i_enable && i_valid)
		in_data_q <= i_data;
end

am_comparator u_comparator (
	.i_block            (in_data_q),
	.i_compare_mask     (i_compare_mask),
	.i_match_mask       (match_mask),
	.i_enable_mask      (enable_mask),
	.o_match            (match),
	.o_match_vector     (match_vector),
	.o_lane_id          (lane_id)
);

am_lock_fsm u_lock_fsm (
	.i_clock            (i_clock),
	.i_rst              (i_rst),
	.i_enable           (i_enable),
	.i_valid            (in_valid_q),
	.i_block_lock       (in_block_lock_q),
	.i_match            (match),
	.i_match_vector     (match_vector),
	.i_valid_thr        (i_valid_thr),
	.i_invalid_thr      (i_invalid_thr),
	.o_match_mask       (match_mask),
	.o_enable_mask      (enable_mask),
	.o_status           (status)
);

bip_checker u_bip_checker (
	.i_clock            (i_clock),
	.i_rst              (i_rst),
	.i_enable           (i_enable),
	.i_valid            (in_valid_q),
	.i_block            (in_data_q),
	.i_start_of_lane    (status.start_of_lane),
	.i_resync           (status.resync),
	.o_error_count      (o_error_count)
);

always_ff @(posedge i_clock)
begin
	if (i_rst)
	begin
		o_valid         <= 1'b0;
		o_am_lock       <= 1'b0;
		o_start_of_lane <= 1'b0;
		o_resync        <= 1'b0;
		o_lane_id       <= '0;
	end
	else if (i_enable)
	begin
		o_valid         <= in_valid_q;
		o_am_lock       <= status.am_lock;
		o_start_of_lane <= status.start_of_lane;
		o_resync        <= status.resync;
		if (status.start_of_lane)
			o_lane_id <= lane_id;                    // locked lane only
	end
	else
	begin
		o_valid         <= 1'b0;
		o_start_of_lane <= 1'b0;
		o_resync        <= 1'b0;
	end
end

// matched markers leave as idle control blocks
always_ff @(posedge i_clock)
begin
	if (i_enable && in_valid_q)
		o_data <= status.start_of_lane ? IDLE_BLOCK : in_data_q;
end

endmodule

//--- tb_am_lock.sv
`timescale 1ns/1ps
`include "am_lock_settings.svh"

module tb_am_lock
	import pcs_block_pkg::*, am_lock_pkg::*;
();

localparam int CLK_NS      = 4;
localparam int WATCHDOG_NS = 20 * `AM_PERIOD * 2 * CLK_NS;  // 20 periods, 2 cycles per block
localparam logic [`NB_THR-1:0] VALID_THR   = 3;
localparam logic [`NB_THR-1:0] INVALID_THR = 2;

logic i_clock = 1'b0;
logic i_rst, i_enable, i_valid, i_block_lock;
coded_block_t i_data;
logic [`NB_THR-1:0] i_valid_thr, i_invalid_thr;
logic [`NB_AM-1:0] i_compare_mask;
coded_block_t o_data;
logic o_valid, o_am_lock, o_start_of_lane, o_resync;
logic [`NB_LANE_ID-1:0] o_lane_id;
logic [`NB_ERR_CNT-1:0] o_error_count;

coded_block_t model_q[$];                 // blocks sent, oldest first
bit           marker_q[$];
logic [7:0]   bip_run;
int           lane, markers_seen, seen_base, resync_base, resync_count;
logic         prev_lock;
logic [`NB_ERR_CNT-1:0] err_base;

always #(CLK_NS/2) i_clock = ~i_clock;

am_lock_top u_dut (.*);

task automatic report_mismatch(input string name, input logic [65:0] exp, input logic [65:0] act);
	$display("FAIL %s expected %0h actual %0h", name, exp, act);
	$display("Done: errors found");
	$fatal(1, "check failed");
endtask

task automatic report_problem(input string what);
	$display("%s", what);
	$display("Done: errors found");
	$fatal(1, "check failed");
endtask

// bit k of the 66-bit word, header lsb first, goes to parity bit k mod 8
function automatic logic [7:0] parity_fold(input coded_block_t b);
	logic [65:0] w;
	logic [7:0]  p;
	w = {b.payload, b.sh};
	p = '0;
	for (int k = 0; k < 66; k++)
		p[k % 8] ^= w[k];
	return p;
endfunction

task automatic send_block(input coded_block_t blk, input bit is_marker);
	if ($urandom % 4 == 0)
	begin
		i_valid = 1'b0;                       // one cycle gap
		@(negedge i_clock);
	end
	i_data  = blk;
	i_valid = 1'b1;
	model_q.push_back(blk);
	marker_q.push_back(is_marker);
	@(negedge i_clock);
	i_valid = 1'b0;
endtask

// marker slot first, then data; mode 0 good, 1 bad bip3, 2 no marker
task automatic send_period(input int mode);
	am_fields_t   f;
	coded_block_t blk;
	logic [7:0]   bip;
	if (mode == 2)
		blk = '{sh: 2'b01, payload: {$urandom, $urandom}};
	else
	begin
		f.am_first  = am_table[lane][47:24];
		f.bip3      = '0;
		f.am_second = am_table[lane][23:0];
		f.bip7      = '0;
		blk         = '{sh: CTRL_SH, payload: f};
		bip         = bip_run ^ parity_fold(blk);
		f.bip3      = (mode == 1) ? ~bip : bip;
		blk.payload = f;
	end
	send_block(blk, mode != 2);
	bip_run = (mode == 2) ? bip_run ^ parity_fold(blk) : 8'h00;
	for (int i = 1; i < `AM_PERIOD; i++)
	begin
		blk = '{sh: 2'b01, payload: {$urandom, $urandom}};
		bip_run ^= parity_fold(blk);
		send_block(blk, 1'b0);
	end
endtask

task automatic drain;
	while (model_q.size() != 0)
		@(negedge i_clock);
	repeat (2) @(negedge i_clock);            // error counter lags by one cycle
endtask

// output checker sampled away from the active edge
always @(negedge i_clock)
begin
	coded_block_t exp;
	bit           was_marker;
	if (!i_rst && o_valid)
	begin
		if (model_q.size() == 0)
			report_problem("output block with no block sent");
		exp        = model_q.pop_front();
		was_marker = marker_q.pop_front();
		if (was_marker)
			markers_seen++;
		assert (o_start_of_lane == (was_marker && o_am_lock))
			else report_mismatch("start_of_lane", was_marker && o_am_lock, o_start_of_lane);
		if (o_start_of_lane)
		begin
			assert (o_data == IDLE_BLOCK) else report_mismatch("replace", IDLE_BLOCK, o_data);
			assert (o_lane_id == lane[1:0]) else report_mismatch("lane_id", lane, o_lane_id);
		end
		else
			assert (o_data == exp) else report_mismatch("passthru", exp, o_data);
	end
	if (!i_rst && o_am_lock && !prev_lock)
	begin
		assert (o_start_of_lane) else report_problem("lock rose off a marker output");
		assert (markers_seen - seen_base == VALID_THR)
			else report_mismatch("lock", VALID_THR, markers_seen - seen_base);
	end
	if (!i_rst && o_resync)
		resync_count++;
	prev_lock = o_am_lock;
end

initial
begin
	#(WATCHDOG_NS);
	$display("watchdog expired before the tests finished");
	$display("Done: errors found");
	$fatal(1, "timeout");
end

initial
begin
	void'($urandom(12613));
	{i_rst, i_enable, i_valid, i_block_lock} = 4'b1000;
	i_data = '0;
	i_valid_thr = VALID_THR;
	i_invalid_thr = INVALID_THR;
	i_compare_mask = '1;
	bip_run = '0;
	{markers_seen, seen_base, resync_count} = '0;
	prev_lock = 1'b0;
	lane = $urandom % `N_LANES;
	repeat (10) @(negedge i_clock);
	i_rst = 1'b0;
	@(negedge i_clock);
	assert ({o_valid, o_am_lock, o_start_of_lane, o_resync} == 0)
		else report_mismatch("reset_status", 0, {o_valid, o_am_lock, o_start_of_lane, o_resync});
	assert (o_error_count == 0) else report_mismatch("reset_errcnt", 0, o_error_count);
	i_valid = 1'b1;                           // strobes are ignored while disabled
	repeat (5)
	begin
		@(negedge i_clock);
		assert (!o_valid) else report_problem("o_valid high while disabled");
	end
	i_valid = 1'b0;
	i_enable = 1'b1;
	i_block_lock = 1'b1;
	repeat (3) @(negedge i_clock);
	repeat (VALID_THR) send_period(0);
	drain();
	assert (o_am_lock) else report_mismatch("lock", 1, o_am_lock);
	err_base = o_error_count;
	send_period(1);
	send_period(1);
	send_period(0);
	drain();
	assert (o_error_count == err_base + 2)
		else report_mismatch("bip", err_base + 2, o_error_count);
	resync_base = resync_count;
	repeat (INVALID_THR - 1)
	begin
		send_period(2);
		drain();
		assert (o_am_lock) else report_mismatch("unlock_early", 1, o_am_lock);
	end
	send_period(2);
	drain();
	assert (!o_am_lock) else report_mismatch("unlock", 0, o_am_lock);
	assert (resync_count == resync_base + 1)
		else report_mismatch("resync", resync_base + 1, resync_count);
	assert (o_error_count == 0) else report_mismatch("resync_errcnt", 0, o_error_count);
	seen_base = markers_seen;
	repeat (VALID_THR) send_period(0);
	drain();
	assert (o_am_lock) else report_mismatch("relock", 1, o_am_lock);
	resync_base = resync_count;
	i_block_lock = 1'b0;
	repeat (4) send_block('{sh: 2'b01, payload: {$urandom, $urandom}}, 1'b0);
	i_block_lock = 1'b1;
	drain();
	assert (!o_am_lock) else report_mismatch("blk_lock_loss", 0, o_am_lock);
	assert (resync_count == resync_base + 1)
		else report_mismatch("blk_resync", resync_base + 1, resync_count);
	seen_base = markers_seen;
	repeat (VALID_THR) send_period(0);
	drain();
	assert (o_am_lock) else report_mismatch("blk_relock", 1, o_am_lock);
	$display("Done: no errors");
	$finish;
end

endmodule

//--- project.f
+incdir+.
pcs_block_pkg.sv
am_lock_pkg.sv
am_comparator.sv
am_lock_fsm.sv
bip_checker.sv
am_lock_top.sv
tb_am_lock.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := project.f
TB_TOP     := tb_am_lock
RTL_TOP    := am_lock_top
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
